// File: hw/llc_split_defines.svh
/* llc split defines
   sizing constants for the burst splitter front end */
`ifndef LLC_SPLIT_DEFINES_SVH
`define LLC_SPLIT_DEFINES_SVH

// byte address width
`define LLC_ADDR_W 32

// log2 of the line size in bytes, 32-byte lines
`define LLC_LINE_OFFS 5

// set associativity
`define LLC_WAYS 4

// scratchpad bytes mapped onto each way
`define LLC_SPM_WAY_BYTES 1024

// descriptor entries between split unit and issue stage
`define LLC_FIFO_DEPTH 4

// transaction id width
`define LLC_ID_W 4

`endif

// File: hw/llc_split_pkg.sv
/* llc split package
   burst, response and state encodings plus request and descriptor types */
`include "llc_split_defines.svh"

package llc_split_pkg;

  // axi burst encoding, wrap is treated as incr downstream
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // axi response encoding, only the two used values
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // split unit fsm
  typedef enum logic {
    SPLIT_IDLE,
    SPLIT_CUT
  } split_state_e;

  // one ar or aw request
  typedef struct packed {
    logic [`LLC_ID_W-1:0]   id;
    logic [`LLC_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    burst_e                 burst;
    logic                   write;
  } ax_req_t;

  // one line sized piece of a request
  typedef struct packed {
    logic [`LLC_ID_W-1:0]   id;
    logic [`LLC_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    burst_e                 burst;
    logic                   rw;
    logic                   spm;
    logic [`LLC_WAYS-1:0]   way_ind;
    resp_e                  resp;
    logic                   last;
  } llc_desc_t;

endpackage

// File: hw/llc_desc_if.sv
/* descriptor link
   connects the split unit, the descriptor FIFO and the issue stage */
`timescale 1ns/1ps

interface llc_desc_if;

  // entry written by the split unit
  llc_split_pkg::llc_desc_t desc;
  // entry at the FIFO head, seen by the issue stage
  llc_split_pkg::llc_desc_t head;
  // one pulse per entry, only while not full
  logic push;
  // one pulse per entry, only while not empty
  logic pop;
  logic full;
  logic empty;

  modport producer (output desc, output push, input full);

  modport buffer (input desc, input push, input pop, output head, output full, output empty);

  modport consumer (output pop, input head, input empty);

endinterface

// File: hw/llc_burst_cutter.sv
/* llc burst cutter
   cuts the current request at the line boundary and picks cached or scratchpad way */
`timescale 1ns/1ps
`include "llc_split_defines.svh"

module llc_burst_cutter (
  input  llc_split_pkg::ax_req_t   curr_i,
  input  logic [`LLC_ADDR_W-1:0]   cached_start_i,
  input  logic [`LLC_ADDR_W-1:0]   cached_end_i,
  input  logic [`LLC_ADDR_W-1:0]   spm_start_i,
  output llc_split_pkg::ax_req_t   next_o,
  output llc_split_pkg::llc_desc_t desc_o
);

  localparam int unsigned line_bytes = 1 << `LLC_LINE_OFFS;

  // line arithmetic
  logic [`LLC_ADDR_W-1:0] line_base;
  logic [`LLC_ADDR_W-1:0] next_base;
  logic [`LLC_ADDR_W-1:0] bytes_on_line;
  logic [7:0]             beats_on_line;

  // scratchpad map, one region per way
  logic [`LLC_ADDR_W-1:0] spm_lo [`LLC_WAYS];
  logic [`LLC_ADDR_W-1:0] spm_hi [`LLC_WAYS];

  // decode results
  logic                 in_cached;
  logic [`LLC_WAYS-1:0] spm_hit;

  // regions are packed back to back from spm_start_i upwards
  always_comb begin
    for (int i = 0; i < `LLC_WAYS; i++) begin
      spm_lo[i] = spm_start_i + `LLC_ADDR_W'(i * `LLC_SPM_WAY_BYTES);
      spm_hi[i] = spm_lo[i] + `LLC_ADDR_W'(`LLC_SPM_WAY_BYTES);
    end
  end

  // end addresses are exclusive
  always_comb begin
    in_cached = (curr_i.addr >= cached_start_i) && (curr_i.addr < cached_end_i);
    for (int i = 0; i < `LLC_WAYS; i++) begin
      // disjoint regions, so at most one bit is set
      spm_hit[i] = (curr_i.addr >= spm_lo[i]) && (curr_i.addr < spm_hi[i]);
    end
  end

  always_comb begin
    // clear the offset bits to get the line base
    line_base     = curr_i.addr & ~`LLC_ADDR_W'(line_bytes - 1);
    next_base     = line_base + `LLC_ADDR_W'(line_bytes);
    // bytes from the start address up to the line end
    bytes_on_line = next_base - curr_i.addr;
    // at most line_bytes beats, fits the len field
    beats_on_line = 8'(((bytes_on_line - 1) >> curr_i.size) + 1);

    // defaults, request passes through unchanged
    next_o         = curr_i;
    desc_o.id      = curr_i.id;
    desc_o.addr    = curr_i.addr;
    desc_o.len     = curr_i.len;
    desc_o.size    = curr_i.size;
    desc_o.burst   = curr_i.burst;
    desc_o.rw      = curr_i.write;
    desc_o.spm     = 1'b0;
    desc_o.way_ind = '0;
    desc_o.resp    = llc_split_pkg::RESP_OKAY;
    desc_o.last    = 1'b1;

    // region select, cached region checked first
    if (in_cached) begin
      desc_o.spm     = 1'b0;
      desc_o.way_ind = '0;
    end else if (|spm_hit) begin
      desc_o.spm     = 1'b1;
      desc_o.way_ind = spm_hit;
    end else begin
      // decode miss goes to way 0 with an error response
      desc_o.spm     = 1'b1;
      desc_o.way_ind = `LLC_WAYS'(1);
      desc_o.resp    = llc_split_pkg::RESP_SLVERR;
    end

    // fixed bursts never leave their line
    if ((curr_i.burst != llc_split_pkg::BURST_FIXED) &&
        ((beats_on_line - 8'd1) < curr_i.len)) begin
      desc_o.len  = beats_on_line - 8'd1;
      desc_o.last = 1'b0;
      // remainder starts on the next line
      next_o.addr = next_base;
      next_o.len  = curr_i.len - beats_on_line;
    end
  end

endmodule

// File: hw/llc_split_unit.sv
/* llc split unit
   holds one accepted request and pushes one line descriptor per free cycle */
`timescale 1ns/1ps
`include "llc_split_defines.svh"

module llc_split_unit (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   ax_valid_i,
  input  llc_split_pkg::ax_req_t ax_req_i,
  input  logic [`LLC_ADDR_W-1:0] cached_start_i,
  input  logic [`LLC_ADDR_W-1:0] cached_end_i,
  input  logic [`LLC_ADDR_W-1:0] spm_start_i,
  output logic                   busy_o,
  llc_desc_if.producer           desc_if
);

  llc_split_pkg::split_state_e state_q;
  llc_split_pkg::split_state_e state_d;

  // remaining part of the burst
  llc_split_pkg::ax_req_t   req_q;
  llc_split_pkg::ax_req_t   next_req;
  llc_split_pkg::llc_desc_t cut_desc;

  logic accept;
  logic push;

  // a request is taken only while idle
  assign accept = ax_valid_i && (state_q == llc_split_pkg::SPLIT_IDLE);
  // one descriptor per cycle unless the FIFO is full
  assign push   = (state_q == llc_split_pkg::SPLIT_CUT) && !desc_if.full;
  assign busy_o = (state_q == llc_split_pkg::SPLIT_CUT);

  assign desc_if.push = push;
  assign desc_if.desc = cut_desc;

  llc_burst_cutter i_cutter (
    .curr_i         (req_q),
    .cached_start_i (cached_start_i),
    .cached_end_i   (cached_end_i),
    .spm_start_i    (spm_start_i),
    .next_o         (next_req),
    .desc_o         (cut_desc)
  );

  always_comb begin
    state_d = state_q;
    case (state_q)
      llc_split_pkg::SPLIT_IDLE: begin
        if (accept) begin
          state_d = llc_split_pkg::SPLIT_CUT;
        end
      end
      llc_split_pkg::SPLIT_CUT: begin
        // done once the last piece is in the FIFO
        if (push && cut_desc.last) begin
          state_d = llc_split_pkg::SPLIT_IDLE;
        end
      end
      default: state_d = llc_split_pkg::SPLIT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= llc_split_pkg::SPLIT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // request register, only meaningful while cutting
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= ax_req_i;
    end else if (push && !cut_desc.last) begin
      // step to the remainder after each pushed piece
      req_q <= next_req;
    end
  end

endmodule

// File: hw/llc_desc_fifo.sv
/* llc descriptor FIFO
   circular buffer between split unit and issue stage, head entry visible */
`timescale 1ns/1ps
`include "llc_split_defines.svh"

module llc_desc_fifo (
  input  logic       clk_i,
  input  logic       arst_n_i,
  llc_desc_if.buffer desc_if
);

  localparam int unsigned depth = `LLC_FIFO_DEPTH;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  // storage
  llc_split_pkg::llc_desc_t mem_q [depth];

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;

  logic do_push;
  logic do_pop;

  assign desc_if.full  = (count_q == cnt_w'(depth));
  assign desc_if.empty = (count_q == '0);
  assign desc_if.head  = mem_q[rd_ptr_q];

  // guarded so a stray strobe cannot corrupt the count
  assign do_push = desc_if.push && !desc_if.full;
  assign do_pop  = desc_if.pop && !desc_if.empty;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // entry storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= desc_if.desc;
    end
  end

endmodule

// File: hw/llc_desc_issue.sv
/* llc descriptor issue
   pops the FIFO head into output registers, one pulse per descriptor */
`timescale 1ns/1ps

module llc_desc_issue (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     stall_i,
  output logic                     desc_valid_o,
  output llc_split_pkg::llc_desc_t desc_o,
  llc_desc_if.consumer             desc_if
);

  logic                     pop;
  logic                     valid_q;
  llc_split_pkg::llc_desc_t desc_q;

  // take the head whenever there is one and nobody holds us
  assign pop         = !desc_if.empty && !stall_i;
  assign desc_if.pop = pop;

  // valid follows the pop by one edge
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= pop;
    end
  end

  // output payload, held between pulses
  always_ff @(posedge clk_i) begin
    if (pop) begin
      desc_q <= desc_if.head;
    end
  end

  assign desc_valid_o = valid_q;
  assign desc_o       = desc_q;

endmodule

// File: hw/llc_split_top.sv
/* llc split top
   request cutter, descriptor FIFO and issue stage behind plain ports */
`timescale 1ns/1ps
`include "llc_split_defines.svh"

module llc_split_top (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // request side
  input  logic                   ax_valid_i,
  input  logic [`LLC_ID_W-1:0]   ax_id_i,
  input  logic [`LLC_ADDR_W-1:0] ax_addr_i,
  input  logic [7:0]             ax_len_i,
  input  logic [2:0]             ax_size_i,
  input  logic [1:0]             ax_burst_i,
  input  logic                   ax_write_i,
  // region bounds
  input  logic [`LLC_ADDR_W-1:0] cached_start_i,
  input  logic [`LLC_ADDR_W-1:0] cached_end_i,
  input  logic [`LLC_ADDR_W-1:0] spm_start_i,
  input  logic                   stall_i,
  output logic                   busy_o,
  // descriptor side
  output logic                   desc_valid_o,
  output logic [`LLC_ID_W-1:0]   desc_id_o,
  output logic [`LLC_ADDR_W-1:0] desc_addr_o,
  output logic [7:0]             desc_len_o,
  output logic [2:0]             desc_size_o,
  output logic [1:0]             desc_burst_o,
  output logic                   desc_rw_o,
  output logic                   desc_spm_o,
  output logic [`LLC_WAYS-1:0]   desc_way_o,
  output logic [1:0]             desc_resp_o,
  output logic                   desc_last_o
);

  llc_split_pkg::ax_req_t   ax_req;
  llc_split_pkg::llc_desc_t out_desc;

  llc_desc_if desc_link ();

  // pack request ports
  assign ax_req.id    = ax_id_i;
  assign ax_req.addr  = ax_addr_i;
  assign ax_req.len   = ax_len_i;
  assign ax_req.size  = ax_size_i;
  assign ax_req.burst = llc_split_pkg::burst_e'(ax_burst_i);
  assign ax_req.write = ax_write_i;

  llc_split_unit i_split (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .ax_valid_i     (ax_valid_i),
    .ax_req_i       (ax_req),
    .cached_start_i (cached_start_i),
    .cached_end_i   (cached_end_i),
    .spm_start_i    (spm_start_i),
    .busy_o         (busy_o),
    .desc_if        (desc_link.producer)
  );

  llc_desc_fifo i_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .desc_if  (desc_link.buffer)
  );

  llc_desc_issue i_issue (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .stall_i      (stall_i),
    .desc_valid_o (desc_valid_o),
    .desc_o       (out_desc),
    .desc_if      (desc_link.consumer)
  );

  // unpack descriptor fields
  assign desc_id_o    = out_desc.id;
  assign desc_addr_o  = out_desc.addr;
  assign desc_len_o   = out_desc.len;
  assign desc_size_o  = out_desc.size;
  assign desc_burst_o = out_desc.burst;
  assign desc_rw_o    = out_desc.rw;
  assign desc_spm_o   = out_desc.spm;
  assign desc_way_o   = out_desc.way_ind;
  assign desc_resp_o  = out_desc.resp;
  assign desc_last_o  = out_desc.last;

endmodule

// File: dv/tb_llc_split.sv
/* llc split testbench
   replays stim file requests and checks every descriptor under random stall */
`timescale 1ns/1ps
`include "llc_split_defines.svh"

module tb_llc_split;

  localparam int unsigned timeout_cycles = 200;
  // fixed region map
  localparam logic [`LLC_ADDR_W-1:0] cached_start = 32'h8000_0000;
  localparam logic [`LLC_ADDR_W-1:0] cached_end   = 32'h9000_0000;
  localparam logic [`LLC_ADDR_W-1:0] spm_start    = 32'h1000_0000;

  logic                   clk;
  logic                   arst_n;
  logic                   ax_valid;
  logic [`LLC_ID_W-1:0]   ax_id;
  logic [`LLC_ADDR_W-1:0] ax_addr;
  logic [7:0]             ax_len;
  logic [2:0]             ax_size;
  logic [1:0]             ax_burst;
  logic                   ax_write;
  logic                   stall;
  logic                   stall_on;
  logic                   busy;
  logic                   desc_valid;
  logic [`LLC_ID_W-1:0]   desc_id;
  logic [`LLC_ADDR_W-1:0] desc_addr;
  logic [7:0]             desc_len;
  logic [2:0]             desc_size;
  logic [1:0]             desc_burst;
  logic                   desc_rw;
  logic                   desc_spm;
  logic [`LLC_WAYS-1:0]   desc_way;
  logic [1:0]             desc_resp;
  logic                   desc_last;

  // lcg state behind the stall pattern
  logic [31:0] rnd_state;
  int          fd;

  llc_split_top i_dut (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .ax_valid_i     (ax_valid),
    .ax_id_i        (ax_id),
    .ax_addr_i      (ax_addr),
    .ax_len_i       (ax_len),
    .ax_size_i      (ax_size),
    .ax_burst_i     (ax_burst),
    .ax_write_i     (ax_write),
    .cached_start_i (cached_start),
    .cached_end_i   (cached_end),
    .spm_start_i    (spm_start),
    .stall_i        (stall),
    .busy_o         (busy),
    .desc_valid_o   (desc_valid),
    .desc_id_o      (desc_id),
    .desc_addr_o    (desc_addr),
    .desc_len_o     (desc_len),
    .desc_size_o    (desc_size),
    .desc_burst_o   (desc_burst),
    .desc_rw_o      (desc_rw),
    .desc_spm_o     (desc_spm),
    .desc_way_o     (desc_way),
    .desc_resp_o    (desc_resp),
    .desc_last_o    (desc_last)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // classic 32-bit lcg step
  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // stall roughly one cycle in four, changed on the falling edge
  always @(negedge clk) begin
    if (stall_on) begin
      rnd_state = next_rand(rnd_state);
      stall = (rnd_state[31:30] == 2'b00);
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_val(input string name, input logic [31:0] obs, input logic [31:0] exp);
    if (obs !== exp) begin
      $display("ERR %s observed 0x%0h expected 0x%0h", name, obs, exp);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // wait for the split unit to drop busy
  task automatic wait_idle();
    int unsigned n;
    n = 0;
    while (busy) begin
      n++;
      if (n >= timeout_cycles) begin
        abort_run("timeout waiting for busy_o to fall");
      end
      @(negedge clk);
    end
  endtask

  // always moves one edge first, so a pulse is never counted twice
  task automatic wait_desc();
    int unsigned n;
    n = 0;
    @(negedge clk);
    while (!desc_valid) begin
      n++;
      if (n >= timeout_cycles) begin
        abort_run("timeout waiting for desc_valid_o");
      end
      @(negedge clk);
    end
  endtask

  // next line tag, comment lines skipped
  task automatic read_tag(output byte tag, output bit ok);
    int    code;
    string rest;
    tag  = 8'h0;
    code = $fscanf(fd, " %c", tag);
    while (code == 1 && tag == "#") begin
      code = $fgets(rest, fd);
      code = $fscanf(fd, " %c", tag);
    end
    ok = (code == 1);
  endtask

  initial begin
    byte         tag;
    bit          ok;
    int          code;
    int          n_req;
    int unsigned len_sum;
    logic [31:0] r_id, r_addr, r_len, r_size, r_burst, r_write, r_cnt;
    logic [31:0] e_id, e_addr, e_len, e_size, e_burst;
    logic [31:0] e_rw, e_spm, e_way, e_resp, e_last;
    clk       = 1'b0;
    arst_n    = 1'b0;
    ax_valid  = 1'b0;
    ax_id     = '0;
    ax_addr   = '0;
    ax_len    = '0;
    ax_size   = '0;
    ax_burst  = '0;
    ax_write  = 1'b0;
    stall     = 1'b0;
    stall_on  = 1'b0;
    rnd_state = 32'd56703;
    n_req     = 0;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;

    // quiet outputs straight after reset
    repeat (10) begin
      @(negedge clk);
      check_val("busy_o", busy, 32'h0);
      check_val("desc_valid_o", desc_valid, 32'h0);
    end

    fd = $fopen("dv/llc_split_stim.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open dv/llc_split_stim.txt");
    end
    stall_on = 1'b1;

    read_tag(tag, ok);
    while (ok) begin
      if (tag != "R") begin
        abort_run($sformatf("unexpected line tag %c where a request was due", tag));
      end
      code = $fscanf(fd, "%h %h %h %h %h %h %h",
                     r_id, r_addr, r_len, r_size, r_burst, r_write, r_cnt);
      if (code != 7) begin
        abort_run("malformed request line in stim file");
      end
      // one request in flight, strobe for a single cycle
      wait_idle();
      ax_valid = 1'b1;
      ax_id    = r_id[`LLC_ID_W-1:0];
      ax_addr  = r_addr;
      ax_len   = r_len[7:0];
      ax_size  = r_size[2:0];
      ax_burst = r_burst[1:0];
      ax_write = r_write[0];
      @(negedge clk);
      ax_valid = 1'b0;
      check_val("busy_o", busy, 32'h1);
      len_sum = 0;
      for (int k = 0; k < int'(r_cnt); k++) begin
        read_tag(tag, ok);
        if (!ok || tag != "D") begin
          abort_run("expected descriptor line missing from stim file");
        end
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", e_id, e_addr, e_len,
                       e_size, e_burst, e_rw, e_spm, e_way, e_resp, e_last);
        if (code != 10) begin
          abort_run("malformed descriptor line in stim file");
        end
        wait_desc();
        check_val("desc_id_o", desc_id, e_id);
        check_val("desc_addr_o", desc_addr, e_addr);
        check_val("desc_len_o", desc_len, e_len);
        check_val("desc_size_o", desc_size, e_size);
        check_val("desc_burst_o", desc_burst, e_burst);
        check_val("desc_rw_o", desc_rw, e_rw);
        check_val("desc_spm_o", desc_spm, e_spm);
        check_val("desc_way_o", desc_way, e_way);
        check_val("desc_resp_o", desc_resp, e_resp);
        check_val("desc_last_o", desc_last, e_last);
        // more pieces still to come than the FIFO holds so the last push is pending
        if (int'(r_cnt) - 1 - k > `LLC_FIFO_DEPTH) begin
          check_val("busy_o", busy, 32'h1);
        end
        len_sum += desc_len + 1;
      end
      // pieces must cover the whole burst
      check_val("desc_len_o sum", len_sum, r_len + 1);
      // last push is two edges ahead of its output pulse
      check_val("busy_o", busy, 32'h0);
      n_req++;
      read_tag(tag, ok);
    end
    $fclose(fd);

    // nothing extra comes out after the final request
    repeat (20) begin
      @(negedge clk);
      check_val("desc_valid_o", desc_valid, 32'h0);
    end
    if (n_req == 0) begin
      abort_run("stim file holds no requests");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// File: dv/llc_split_stim.txt
# R id addr len size burst write n_desc, all hex, request followed by its descriptors
# D id addr len size burst rw spm way_ind resp last
R 1 80000000 03 2 1 0 1
D 1 80000000 03 2 1 0 0 0 0 1
R 2 80000104 11 2 1 1 3
D 2 80000104 06 2 1 1 0 0 0 0
D 2 80000120 07 2 1 1 0 0 0 0
D 2 80000140 02 2 1 1 0 0 0 1
R 3 80000018 05 2 2 0 2
D 3 80000018 01 2 2 0 0 0 0 0
D 3 80000020 03 2 2 0 0 0 0 1
R 4 80000018 07 2 0 0 1
D 4 80000018 07 2 0 0 0 0 0 1
R 5 10000000 00 2 1 0 1
D 5 10000000 00 2 1 0 1 1 0 1
R 6 100004a0 00 2 1 1 1
D 6 100004a0 00 2 1 1 1 2 0 1
R 7 10000800 00 2 1 0 1
D 7 10000800 00 2 1 0 1 4 0 1
R 8 10000fe0 00 2 1 0 1
D 8 10000fe0 00 2 1 0 1 8 0 1
R 9 10001000 00 2 1 0 1
D 9 10001000 00 2 1 0 1 1 2 1
R a 80002000 ff 0 1 0 8
D a 80002000 1f 0 1 0 0 0 0 0
D a 80002020 1f 0 1 0 0 0 0 0
D a 80002040 1f 0 1 0 0 0 0 0
D a 80002060 1f 0 1 0 0 0 0 0
D a 80002080 1f 0 1 0 0 0 0 0
D a 800020a0 1f 0 1 0 0 0 0 0
D a 800020c0 1f 0 1 0 0 0 0 0
D a 800020e0 1f 0 1 0 0 0 0 1

// File: tb.f
+incdir+hw
hw/llc_split_pkg.sv
hw/llc_desc_if.sv
hw/llc_burst_cutter.sv
hw/llc_split_unit.sv
hw/llc_desc_fifo.sv
hw/llc_desc_issue.sv
hw/llc_split_top.sv
dv/tb_llc_split.sv
